/* source/copper_defines.svh */
`ifndef COPPER_DEFINES_SVH
`define COPPER_DEFINES_SVH

// Datapath widths
`define COPP_PC_W           11
`define COPP_WORD_W         16
`define COPP_POS_W          11

// 640x480 timing, totals include blanking
`define COPP_H_TOTAL        800
`define COPP_V_TOTAL        525

// Restart lands this many pixels before the end of the last line
`define COPP_RESTART_H_OFS  5

// XR register number of the copper control register
`define XR_COPP_CTRL        4'h1

// Colour memory window, palette index goes in the low byte
`define XR_COLOR_BASE       16'h8000

`endif

/* source/copper_isa_pkg.sv */
`default_nettype none

package copper_isa_pkg;

`include "copper_defines.svh"

    // Top nibble of the first instruction word
    typedef enum logic [3:0] {
        OP_WAIT  = 4'b0000,
        OP_SKIP  = 4'b0010,
        OP_JMP   = 4'b0100,
        OP_MOVER = 4'b1001,
        OP_MOVEP = 4'b1011
    } insn_op_t;

    // Fetch and execute phases
    typedef enum logic [2:0] {
        ST_INIT   = 3'b000,
        ST_WAIT   = 3'b001,
        ST_LATCH1 = 3'b010,
        ST_LATCH2 = 3'b011,
        ST_EXEC   = 3'b100
    } seq_state_t;

    // How the PC moves when an instruction retires
    typedef enum logic [1:0] {
        PC_STEP1 = 2'b00,
        PC_STEP3 = 2'b01,
        PC_JUMP  = 2'b10
    } pc_sel_t;

    // WAIT and SKIP layout
    typedef struct packed {
        insn_op_t               op;
        logic                   pad_y;
        logic [`COPP_POS_W-1:0] y;
        logic                   pad_x;
        logic [`COPP_POS_W-1:0] x;
        logic [1:0]             pad_flags;
        logic                   ign_h;
        logic                   ign_v;
    } insn_pos_t;

    // JMP and MOVEx layout
    typedef struct packed {
        insn_op_t                op;
        logic [11:0]             target;
        logic [`COPP_WORD_W-1:0] data;
    } insn_move_t;

    typedef union packed {
        insn_pos_t  pos;
        insn_move_t mv;
    } copp_insn_u;

endpackage

`default_nettype wire

/* source/copper_video_pkg.sv */
`default_nettype none

package copper_video_pkg;

`include "copper_defines.svh"

    // Raw counter value, native resolution
    typedef logic [`COPP_POS_W-1:0] beam_pos_t;

    // Address on the shared XR write port
    typedef logic [15:0] xr_addr_t;

endpackage

`default_nettype wire

/* source/copper_exec_if.sv */
`default_nettype none

`include "copper_defines.svh"

interface copper_exec_if;
    import copper_isa_pkg::*;

    // Sequencer side
    copp_insn_u             insn;
    logic                   exec_en;

    // Executor side, all combinational
    logic                   done;
    pc_sel_t                pc_sel;
    logic [`COPP_PC_W-1:0]  jump_pc;

    modport seq (
        output insn, exec_en,
        input  done, pc_sel, jump_pc
    );

    modport exec (
        input  insn, exec_en,
        output done, pc_sel, jump_pc
    );

endinterface

`default_nettype wire

/* source/copper_ctrl_reg.sv */
`default_nettype none

`include "copper_defines.svh"

module copper_ctrl_reg (
    input  wire logic                    clk,
    input  wire logic                    copp_reset,
    input  wire logic                    reg_wr_i,
    input  wire logic [3:0]              reg_num_i,
    input  wire logic [`COPP_WORD_W-1:0] reg_data_i,
    output logic                         copp_en_o,
    output logic [`COPP_PC_W-1:0]        init_pc_o
);

    // Bit 15 enables, bits 10:0 give the restart PC
    // Bits 14:11 are reserved and dropped
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            copp_en_o <= 1'b0;
            init_pc_o <= '0;
        end else if (reg_wr_i && reg_num_i == `XR_COPP_CTRL) begin
            copp_en_o <= reg_data_i[15];
            init_pc_o <= reg_data_i[`COPP_PC_W-1:0];
        end
        // Other register numbers belong to someone else
    end

endmodule

`default_nettype wire

/* source/copper_fetch_seq.sv */
`default_nettype none

`include "copper_defines.svh"

module copper_fetch_seq (
    input  wire logic                      clk,
    input  wire logic                      copp_reset,
    input  wire logic                      copp_en_i,
    input  wire logic [`COPP_PC_W-1:0]     init_pc_i,
    input  wire logic [`COPP_WORD_W-1:0]   rd_data_i,
    input  wire copper_video_pkg::beam_pos_t h_count_i,
    input  wire copper_video_pkg::beam_pos_t v_count_i,
    output logic [`COPP_PC_W-1:0]          rd_addr_o,
    output logic                           rd_en_o,
    copper_exec_if.seq                     exec_if
);
    import copper_isa_pkg::*;
    import copper_video_pkg::*;

    seq_state_t             state_q;
    logic [`COPP_PC_W-1:0]  pc_q;
    logic                   rd_en_q;
    copp_insn_u             insn_q;
    logic                   frame_restart;

    // Restart point, a few pixels before the end of the last line
    always_comb begin
        frame_restart = (h_count_i == beam_pos_t'(`COPP_H_TOTAL - `COPP_RESTART_H_OFS))
                     && (v_count_i == beam_pos_t'(`COPP_V_TOTAL - 1));
    end

    assign rd_addr_o = pc_q;
    assign rd_en_o   = rd_en_q;

    // Restart cycle never executes, so no write can slip through it
    assign exec_if.exec_en = (state_q == ST_EXEC) && copp_en_i && !frame_restart;
    assign exec_if.insn    = insn_q;

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state_q <= ST_INIT;
            pc_q    <= '0;
            rd_en_q <= 1'b0;
        end else if (frame_restart) begin
            state_q <= ST_INIT;
            pc_q    <= init_pc_i;
            rd_en_q <= 1'b0;
        end else if (copp_en_i) begin
            case (state_q)
                // Only after restart or enable, prefetch first word
                ST_INIT: begin
                    state_q <= ST_WAIT;
                    rd_en_q <= 1'b1;
                end
                // First word address on the bus, move on to the second
                ST_WAIT: begin
                    state_q <= ST_LATCH1;
                    pc_q    <= pc_q + 1'b1;
                    rd_en_q <= 1'b1;
                end
                ST_LATCH1: begin
                    state_q <= ST_LATCH2;
                end
                // Second word arrives, memory idle until next fetch
                ST_LATCH2: begin
                    state_q <= ST_EXEC;
                    rd_en_q <= 1'b0;
                end
                // PC sits on the second word here
                ST_EXEC: begin
                    if (exec_if.done) begin
                        case (exec_if.pc_sel)
                            PC_STEP3: pc_q <= pc_q + 2'd3;
                            PC_JUMP:  pc_q <= exec_if.jump_pc;
                            default:  pc_q <= pc_q + 1'b1;
                        endcase
                        state_q <= ST_WAIT;
                        rd_en_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_INIT;
                end
            endcase
        end
    end

    // Instruction halves, high word first
    always_ff @(posedge clk) begin
        if (copp_en_i && !frame_restart) begin
            if (state_q == ST_LATCH1) begin
                insn_q[31:16] <= rd_data_i;
            end
            if (state_q == ST_LATCH2) begin
                insn_q[15:0] <= rd_data_i;
            end
        end
    end

endmodule

`default_nettype wire

/* source/copper_exec.sv */
`default_nettype none

`include "copper_defines.svh"

module copper_exec (
    input  wire logic                        clk,
    input  wire logic                        copp_reset,
    input  wire copper_video_pkg::beam_pos_t h_count_i,
    input  wire copper_video_pkg::beam_pos_t v_count_i,
    input  wire logic                        xr_reg_busy_i,
    input  wire logic                        color_busy_i,
    output logic                             xr_wr_en_o,
    output copper_video_pkg::xr_addr_t       xr_wr_addr_o,
    output logic [`COPP_WORD_W-1:0]          xr_wr_data_o,
    copper_exec_if.exec                      exec_if
);
    import copper_isa_pkg::*;
    import copper_video_pkg::*;

    logic       h_ok;
    logic       v_ok;
    logic       beam_hit;
    logic       is_move;
    xr_addr_t   wr_addr_d;

    // Each axis passes once reached, or when ignored
    always_comb begin
        h_ok     = exec_if.insn.pos.ign_h || (h_count_i >= exec_if.insn.pos.x);
        v_ok     = exec_if.insn.pos.ign_v || (v_count_i >= exec_if.insn.pos.y);
        beam_hit = h_ok && v_ok;
    end

    assign exec_if.jump_pc = exec_if.insn.mv.target[`COPP_PC_W-1:0];

    always_comb begin
        exec_if.done   = 1'b1;
        exec_if.pc_sel = PC_STEP1;
        is_move        = 1'b0;
        wr_addr_d      = '0;
        case (exec_if.insn.mv.op)
            // Both axes ignored means park until restart
            OP_WAIT: begin
                exec_if.done = beam_hit
                            && !(exec_if.insn.pos.ign_h && exec_if.insn.pos.ign_v);
            end
            OP_SKIP: begin
                if (beam_hit) begin
                    exec_if.pc_sel = PC_STEP3;
                end
            end
            OP_JMP: begin
                exec_if.pc_sel = PC_JUMP;
            end
            // Moves stall while the host owns the target
            OP_MOVER: begin
                is_move      = 1'b1;
                exec_if.done = !xr_reg_busy_i;
                wr_addr_d    = xr_addr_t'(exec_if.insn.mv.target[7:0]);
            end
            OP_MOVEP: begin
                is_move      = 1'b1;
                exec_if.done = !color_busy_i;
                wr_addr_d    = `XR_COLOR_BASE + xr_addr_t'(exec_if.insn.mv.target[7:0]);
            end
            // Illegal opcode acts as a NOP
            default: ;
        endcase
    end

    // Strobe lasts one cycle, sequencer is back in WAIT by then
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            xr_wr_en_o <= 1'b0;
        end else begin
            xr_wr_en_o <= exec_if.exec_en && exec_if.done && is_move;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_if.exec_en && exec_if.done && is_move) begin
            xr_wr_addr_o <= wr_addr_d;
            xr_wr_data_o <= exec_if.insn.mv.data;
        end
    end

endmodule

`default_nettype wire

/* source/copper_top.sv */
`default_nettype none

`include "copper_defines.svh"

module copper_top (
    input  wire logic                        clk,
    input  wire logic                        copp_reset,
    input  wire logic [`COPP_WORD_W-1:0]     coppermem_rd_data_i,
    input  wire logic                        copp_reg_wr_i,
    input  wire logic [3:0]                  copp_reg_num_i,
    input  wire logic [`COPP_WORD_W-1:0]     copp_reg_data_i,
    input  wire copper_video_pkg::beam_pos_t h_count_i,
    input  wire copper_video_pkg::beam_pos_t v_count_i,
    input  wire logic                        xr_reg_busy_i,
    input  wire logic                        color_busy_i,
    output logic [`COPP_PC_W-1:0]            coppermem_rd_addr_o,
    output logic                             coppermem_rd_en_o,
    output logic                             xr_wr_en_o,
    output copper_video_pkg::xr_addr_t       xr_wr_addr_o,
    output logic [`COPP_WORD_W-1:0]          xr_wr_data_o
);

    logic                   copp_en;
    logic [`COPP_PC_W-1:0]  init_pc;

    // Sequencer to executor link
    copper_exec_if exec_if ();

    copper_ctrl_reg ctrl_reg (
        .clk        (clk),
        .copp_reset (copp_reset),
        .reg_wr_i   (copp_reg_wr_i),
        .reg_num_i  (copp_reg_num_i),
        .reg_data_i (copp_reg_data_i),
        .copp_en_o  (copp_en),
        .init_pc_o  (init_pc)
    );

    copper_fetch_seq fetch_seq (
        .clk        (clk),
        .copp_reset (copp_reset),
        .copp_en_i  (copp_en),
        .init_pc_i  (init_pc),
        .rd_data_i  (coppermem_rd_data_i),
        .h_count_i  (h_count_i),
        .v_count_i  (v_count_i),
        .rd_addr_o  (coppermem_rd_addr_o),
        .rd_en_o    (coppermem_rd_en_o),
        .exec_if    (exec_if.seq)
    );

    copper_exec exec (
        .clk           (clk),
        .copp_reset    (copp_reset),
        .h_count_i     (h_count_i),
        .v_count_i     (v_count_i),
        .xr_reg_busy_i (xr_reg_busy_i),
        .color_busy_i  (color_busy_i),
        .xr_wr_en_o    (xr_wr_en_o),
        .xr_wr_addr_o  (xr_wr_addr_o),
        .xr_wr_data_o  (xr_wr_data_o),
        .exec_if       (exec_if.exec)
    );

endmodule

`default_nettype wire

/* verif/copper_props.sv */
`default_nettype none

module copper_props (
    input  wire logic        clk,
    input  wire logic        copp_reset,
    input  wire logic        rd_en_i,
    input  wire logic        wr_en_i,
    input  wire logic [15:0] wr_addr_i,
    input  wire logic        reg_busy_i,
    input  wire logic        color_busy_i
);

    // Number of failed assertions so far
    int fail_cnt = 0;

    // One move gives a single pulse
    wr_single_pulse: assert property (@(posedge clk) disable iff (copp_reset)
        wr_en_i |=> !wr_en_i)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("write strobe high in two consecutive cycles");
    end

    // Register window sits below the colour base
    // Busy is judged in the EXEC cycle, one before the strobe
    reg_wr_not_busy: assert property (@(posedge clk) disable iff (copp_reset)
        wr_en_i && !wr_addr_i[15] |-> $past(!reg_busy_i))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("register write issued while the register file was busy");
    end

    color_wr_not_busy: assert property (@(posedge clk) disable iff (copp_reset)
        wr_en_i && wr_addr_i[15] |-> $past(!color_busy_i))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("colour write issued while colour memory was busy");
    end

    // No fetch straight out of reset
    rd_idle_after_reset: assert property (@(posedge clk)
        copp_reset |=> !rd_en_i)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("read strobe high in the cycle after reset");
    end

endmodule

`default_nettype wire

/* verif/copper_tb.sv */
`default_nettype none

`include "copper_defines.svh"

module copper_tb;

    // Opcodes of the instruction set
    localparam logic [3:0] OPC_WAIT  = 4'b0000;
    localparam logic [3:0] OPC_SKIP  = 4'b0010;
    localparam logic [3:0] OPC_JMP   = 4'b0100;
    localparam logic [3:0] OPC_MOVER = 4'b1001;
    localparam logic [3:0] OPC_MOVEP = 4'b1011;

    localparam int RESET_CYC = 10;
    // WAIT test sweeps under two lines and every other test is short
    localparam int SWEEP_CYC   = 2 * `COPP_H_TOTAL;
    localparam int TEST_CYC    = 200;
    localparam int CYCLE_LIMIT = RESET_CYC + SWEEP_CYC + 6 * TEST_CYC;

    localparam logic [10:0] RESTART_H = `COPP_H_TOTAL - `COPP_RESTART_H_OFS;
    localparam logic [10:0] RESTART_V = `COPP_V_TOTAL - 1;

    // Expected write with the earliest beam position it may show at
    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] data;
        logic [10:0] min_h;
        logic [10:0] min_v;
    } exp_wr_t;

    logic        clk;
    logic        copp_reset;
    logic [15:0] rd_data;
    logic        reg_wr;
    logic [3:0]  reg_num;
    logic [15:0] reg_data;
    logic [10:0] h_cnt;
    logic [10:0] v_cnt;
    logic        reg_busy;
    logic        color_busy;
    logic [10:0] rd_addr;
    logic        rd_en;
    logic        wr_en;
    logic [15:0] wr_addr;
    logic [15:0] wr_data;

    logic [15:0] prog_mem [0:2047];
    exp_wr_t     exp_q [$];
    logic [10:0] load_ptr;
    logic [31:0] lfsr;
    logic        sweep_beam;
    logic        rand_busy;
    int          cycles;
    int          errors;
    int          tests_run;

    copper_top UUT (
        .clk                 (clk),
        .copp_reset          (copp_reset),
        .coppermem_rd_data_i (rd_data),
        .copp_reg_wr_i       (reg_wr),
        .copp_reg_num_i      (reg_num),
        .copp_reg_data_i     (reg_data),
        .h_count_i           (h_cnt),
        .v_count_i           (v_cnt),
        .xr_reg_busy_i       (reg_busy),
        .color_busy_i        (color_busy),
        .coppermem_rd_addr_o (rd_addr),
        .coppermem_rd_en_o   (rd_en),
        .xr_wr_en_o          (wr_en),
        .xr_wr_addr_o        (wr_addr),
        .xr_wr_data_o        (wr_data)
    );

    // Port level protocol checks
    bind copper_top copper_props props (
        .clk          (clk),
        .copp_reset   (copp_reset),
        .rd_en_i      (coppermem_rd_en_o),
        .wr_en_i      (xr_wr_en_o),
        .wr_addr_i    (xr_wr_addr_o),
        .reg_busy_i   (xr_reg_busy_i),
        .color_busy_i (color_busy_i)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Program memory with data one cycle after the strobe
    always @(posedge clk) begin
        if (rd_en) begin
            rd_data <= prog_mem[rd_addr];
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles with tests still open", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Write monitor samples mid cycle when everything has settled
    always @(negedge clk) begin
        exp_wr_t e;
        if (wr_en) begin
            if (exp_q.size() == 0) begin
                $display("Write of %h to %h at time %0t was not expected",
                         wr_data, wr_addr, $time);
                errors = errors + 1;
            end else begin
                e = exp_q.pop_front();
                assert (wr_addr == e.addr) else begin
                    $display("CHECK FAILED time %0t xr_wr_addr_o expected %h actual %h",
                             $time, e.addr, wr_addr);
                    errors = errors + 1;
                end
                assert (wr_data == e.data) else begin
                    $display("CHECK FAILED time %0t xr_wr_data_o expected %h actual %h",
                             $time, e.data, wr_data);
                    errors = errors + 1;
                end
                assert (h_cnt >= e.min_h) else begin
                    $display("CHECK FAILED time %0t h_count_i expected >= %0d actual %0d",
                             $time, e.min_h, h_cnt);
                    errors = errors + 1;
                end
                assert (v_cnt >= e.min_v) else begin
                    $display("CHECK FAILED time %0t v_count_i expected >= %0d actual %0d",
                             $time, e.min_v, v_cnt);
                    errors = errors + 1;
                end
            end
        end
    end

    // Right shifting Galois form
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // WAIT and SKIP word pair
    function automatic logic [31:0] pos_insn(input logic [3:0] op, input logic [10:0] y,
                                             input logic [10:0] x, input logic ign_h,
                                             input logic ign_v);
        pos_insn = {op, 1'b0, y, 1'b0, x, 2'b00, ign_h, ign_v};
    endfunction

    // JMP and move word pair
    function automatic logic [31:0] move_insn(input logic [3:0] op, input logic [11:0] target,
                                              input logic [15:0] data);
        move_insn = {op, target, data};
    endfunction

    // Inputs change just after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (sweep_beam) begin
            if (h_cnt == `COPP_H_TOTAL - 1) begin
                h_cnt = '0;
                v_cnt = v_cnt + 1'b1;
            end else begin
                h_cnt = h_cnt + 1'b1;
            end
        end
        // One LFSR step per busy bit
        if (rand_busy) begin
            lfsr       = lfsr_next(lfsr);
            reg_busy   = lfsr[0];
            lfsr       = lfsr_next(lfsr);
            color_busy = lfsr[0];
        end
    endtask

    task automatic put_insn(input logic [31:0] insn);
        prog_mem[load_ptr]        = insn[31:16];
        prog_mem[load_ptr + 1'b1] = insn[15:0];
        load_ptr = load_ptr + 2'd2;
    endtask

    task automatic expect_write(input logic [15:0] addr, input logic [15:0] data,
                                input logic [10:0] min_h, input logic [10:0] min_v);
        exp_q.push_back({addr, data, min_h, min_v});
    endtask

    // One cycle on the restart point puts the PC on the start address
    task automatic restart_frame(input logic [10:0] start);
        h_cnt = RESTART_H;
        v_cnt = RESTART_V;
        next_cycle();
        h_cnt = '0;
        v_cnt = '0;
        assert (rd_addr == start) else begin
            $display("CHECK FAILED time %0t coppermem_rd_addr_o expected %h actual %h",
                     $time, start, rd_addr);
            errors = errors + 1;
        end
    endtask

    task automatic start_program(input logic [10:0] start);
        reg_wr   = 1'b1;
        reg_num  = `XR_COPP_CTRL;
        reg_data = {1'b1, 4'b0000, start};
        next_cycle();
        reg_wr = 1'b0;
        restart_frame(start);
    endtask

    task automatic drain_writes();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run = tests_run + 1;
        if (errors == err_before) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests_run, name, errors - err_before);
        end
    endtask

    initial begin
        int          err0;
        logic [7:0]  idx;
        copp_reset = 1'b1;
        rd_data    = '0;
        reg_wr     = 1'b0;
        reg_num    = '0;
        reg_data   = '0;
        h_cnt      = '0;
        v_cnt      = '0;
        reg_busy   = 1'b0;
        color_busy = 1'b0;
        sweep_beam = 1'b0;
        rand_busy  = 1'b0;
        lfsr       = 32'hc929;
        errors     = 0;
        tests_run  = 0;
        cycles     = 0;
        // Illegal opcode F with the address in the low bits
        for (int i = 0; i < 2048; i++) begin
            prog_mem[i] = {4'hf, 1'b0, i[10:0]};
        end
        repeat (RESET_CYC) next_cycle();
        copp_reset = 1'b0;

        // Enable still clear after reset
        err0 = errors;
        restart_frame(11'h000);
        for (int n = 0; n < 20; n++) begin
            next_cycle();
            assert (!rd_en) else begin
                $display("CHECK FAILED time %0t coppermem_rd_en_o expected 0 actual %b",
                         $time, rd_en);
                errors = errors + 1;
            end
            assert (!wr_en) else begin
                $display("CHECK FAILED time %0t xr_wr_en_o expected 0 actual %b",
                         $time, wr_en);
                errors = errors + 1;
            end
        end
        report_test("disabled", err0);

        err0 = errors;
        load_ptr = 11'h010;
        put_insn(move_insn(OPC_MOVER, 12'h00a, 16'h1111));
        put_insn(move_insn(OPC_MOVEP, 12'h03c, 16'h2222));
        put_insn(move_insn(OPC_MOVER, 12'h0f0, 16'h3333));
        put_insn(pos_insn(OPC_WAIT, 0, 0, 1'b1, 1'b1));
        expect_write(16'h000a, 16'h1111, 0, 0);
        expect_write(`XR_COLOR_BASE + 16'h003c, 16'h2222, 0, 0);
        expect_write(16'h00f0, 16'h3333, 0, 0);
        start_program(11'h010);
        drain_writes();
        report_test("moves", err0);

        // Second WAIT ignores V since the beam never gets to line 500
        err0 = errors;
        load_ptr = 11'h100;
        put_insn(pos_insn(OPC_WAIT, 11'd9, 11'd100, 1'b0, 1'b0));
        put_insn(move_insn(OPC_MOVER, 12'h003, 16'h5a01));
        put_insn(pos_insn(OPC_WAIT, 11'd500, 11'd400, 1'b0, 1'b1));
        put_insn(move_insn(OPC_MOVEP, 12'h007, 16'h5a02));
        put_insn(pos_insn(OPC_WAIT, 0, 0, 1'b1, 1'b1));
        expect_write(16'h0003, 16'h5a01, 11'd100, 11'd9);
        expect_write(`XR_COLOR_BASE + 16'h0007, 16'h5a02, 11'd400, 0);
        start_program(11'h100);
        v_cnt = 11'd8;
        sweep_beam = 1'b1;
        drain_writes();
        sweep_beam = 1'b0;
        h_cnt = '0;
        v_cnt = '0;
        report_test("wait", err0);

        // Beam parked at 0,0 so the first SKIP is taken and the second not
        err0 = errors;
        load_ptr = 11'h200;
        put_insn(pos_insn(OPC_SKIP, 0, 0, 1'b0, 1'b0));
        put_insn(move_insn(OPC_MOVER, 12'h001, 16'hdead));
        put_insn(pos_insn(OPC_SKIP, 11'd300, 0, 1'b0, 1'b0));
        put_insn(move_insn(OPC_MOVER, 12'h002, 16'h4444));
        put_insn(move_insn(OPC_MOVEP, 12'h001, 16'h5555));
        put_insn(pos_insn(OPC_WAIT, 0, 0, 1'b1, 1'b1));
        expect_write(16'h0002, 16'h4444, 0, 0);
        expect_write(`XR_COLOR_BASE + 16'h0001, 16'h5555, 0, 0);
        start_program(11'h200);
        drain_writes();
        report_test("skip", err0);

        err0 = errors;
        load_ptr = 11'h300;
        put_insn(move_insn(OPC_JMP, 12'h340, 16'h0000));
        put_insn(move_insn(OPC_MOVER, 12'h005, 16'hbad0));
        load_ptr = 11'h340;
        put_insn(move_insn(OPC_MOVER, 12'h006, 16'h6666));
        put_insn(pos_insn(OPC_WAIT, 0, 0, 1'b1, 1'b1));
        expect_write(16'h0006, 16'h6666, 0, 0);
        start_program(11'h300);
        drain_writes();
        // Next frame runs the same program from the top
        expect_write(16'h0006, 16'h6666, 0, 0);
        restart_frame(11'h300);
        drain_writes();
        report_test("jump and restart", err0);

        // Alternating targets so both busy inputs stall moves
        err0 = errors;
        load_ptr = 11'h400;
        for (int n = 0; n < 8; n++) begin
            idx = 8'h20 + n[7:0];
            if (n[0]) begin
                put_insn(move_insn(OPC_MOVEP, {4'h0, idx}, {8'hc0, idx}));
                expect_write(`XR_COLOR_BASE + {8'h00, idx}, {8'hc0, idx}, 0, 0);
            end else begin
                put_insn(move_insn(OPC_MOVER, {4'h0, idx}, {8'h70, idx}));
                expect_write({8'h00, idx}, {8'h70, idx}, 0, 0);
            end
        end
        put_insn(pos_insn(OPC_WAIT, 0, 0, 1'b1, 1'b1));
        rand_busy = 1'b1;
        start_program(11'h400);
        drain_writes();
        rand_busy  = 1'b0;
        reg_busy   = 1'b0;
        color_busy = 1'b0;
        report_test("back-pressure", err0);

        $display("Finished %0d tests, %0d check errors, %0d assertion failures",
                 tests_run, errors, UUT.props.fail_cnt);
        if (errors == 0 && UUT.props.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* copper.f */
+incdir+source
source/copper_isa_pkg.sv
source/copper_video_pkg.sv
source/copper_exec_if.sv
source/copper_ctrl_reg.sv
source/copper_fetch_seq.sv
source/copper_exec.sv
source/copper_top.sv
verif/copper_props.sv
verif/copper_tb.sv

/* Bender.yml */
package:
  name: copper

sources:
  - include_dirs:
      - source
    files:
      - source/copper_isa_pkg.sv
      - source/copper_video_pkg.sv
      - source/copper_exec_if.sv
      - source/copper_ctrl_reg.sv
      - source/copper_fetch_seq.sv
      - source/copper_exec.sv
      - source/copper_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/copper_props.sv
      - verif/copper_tb.sv
